//--- compile.f
+incdir+hw
hw/ex_pkg.sv
hw/id_ex_reg.sv
hw/ex_alu.sv
hw/mem_access_fsm.sv
hw/ack_wait_timer.sv
hw/ex_wb_reg.sv
hw/ex_stage_top.sv
sim/tb_mem_model.sv
sim/tb_ex_stage.sv

//--- run_sim.sh
#!/bin/sh
# build and run the execute slice testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_ex_stage -f compile.f -o Vtb_ex_stage

# the simulator exit code is not trusted, the log decides
./obj_dir/Vtb_ex_stage > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
	exit 1
fi
grep -qF "*** TEST PASSED ***" sim.log
exit 0

//--- sim/tb_ex_stage.sv
`timescale 1ns/1ps
`include "ex_consts.svh"

module tb_ex_stage import ex_pkg::*; ();

	localparam int ROWS  = 20;
	localparam int LIMIT = 16 + ROWS * (`EX_ACK_TIMEOUT + 20);

	typedef struct {
		ex_kind_e    kind;
		alu_op_e     op;
		logic [31:0] op1;
		logic [31:0] op2;
		logic [31:0] rs2o;
		logic [4:0]  rd;
		logic [31:0] pc;
		logic [31:0] imm;
		int          stall_n;
		logic        mute;
	} row_t;

	typedef struct {
		logic        we;
		logic [4:0]  rd;
		logic [31:0] data;
		logic        chk_data;
		logic        taken;
		logic [31:0] target;
		logic        chk_target;
	} rec_t;

	// one data memory request as the port should present it
	typedef struct {
		logic        we;
		logic [31:0] addr;
		logic [31:0] wdata;
	} acc_t;

	logic clk = 1'b0, rst_n = 1'b0, stall = 1'b0, id_valid = 1'b0, mute = 1'b0;
	ex_kind_e id_kind = EX_ALU;
	alu_op_e id_alu_op = ALU_ADD;
	logic [`EX_XLEN-1:0] id_op1 = '0, id_op2 = '0, id_rs2o = '0, id_pc = '0, id_imm = '0;
	logic [`EX_RADDR_W-1:0] id_rd = '0;
	logic id_ready, mem_req, mem_we, mem_ack, wb_valid, wb_we, br_taken, mem_err;
	logic [`EX_XLEN-1:0] mem_addr, mem_wdata, mem_rdata, wb_data, br_target;
	logic [`EX_RADDR_W-1:0] wb_rd;

	row_t rows [ROWS];
	rec_t exp_q [$];
	acc_t acc_q [$];
	logic [31:0] shadow [logic [31:0]]; // expected memory contents
	int cyc = 0;
	logic req_prev = 1'b0;

	ex_stage_top dut (.*);

	tb_mem_model mem (.clk, .rst_n, .mute, .req(mem_req), .we(mem_we), .addr(mem_addr),
		.wdata(mem_wdata), .ack(mem_ack), .rdata(mem_rdata));

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc > LIMIT) begin
			$display("timeout, records still pending after %0d cycles", cyc);
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	end

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (exp === got) else begin
			$display("Fail %s exp=%h got=%h", name, exp, got);
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond) else begin
			$display("%s", what);
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	endtask

	function automatic rec_t expect_rec(input row_t r);
		rec_t e;
		logic [31:0] res;
		alu_op_e op;
		acc_t a;
		op = (r.kind == EX_LOAD || r.kind == EX_STORE) ? ALU_ADD : r.op;
		case (op)
			ALU_ADD: res = r.op1 + r.op2;
			ALU_SUB: res = r.op1 - r.op2;
			ALU_AND: res = r.op1 & r.op2;
			ALU_OR:  res = r.op1 | r.op2;
			ALU_XOR: res = r.op1 ^ r.op2;
			ALU_SLL: res = r.op1 << r.op2[4:0];
			ALU_SRL: res = r.op1 >> r.op2[4:0];
			default: res = ($signed(r.op1) < $signed(r.op2)) ? 32'd1 : 32'd0;
		endcase
		e.rd = r.rd;
		e.data = res;
		e.chk_data = !r.mute;
		e.we = (r.kind == EX_ALU) || (r.kind == EX_LOAD && !r.mute);
		e.taken = (r.kind == EX_BRANCH) && (res != 0);
		e.target = r.pc + r.imm;
		e.chk_target = (r.kind == EX_BRANCH);
		if (r.kind == EX_STORE)
			shadow[res] = r.rs2o;
		if (r.kind == EX_LOAD)
			e.data = shadow.exists(res) ? shadow[res] : res ^ 32'h5a5a_c3c3;
		if (r.kind == EX_LOAD || r.kind == EX_STORE) begin
			a.we    = (r.kind == EX_STORE);
			a.addr  = res;
			a.wdata = r.rs2o;
			acc_q.push_back(a);
		end
		return e;
	endfunction

	// scoreboard and handshake monitor sampled mid-cycle
	always @(negedge clk) begin
		rec_t e;
		acc_t a;
		if (rst_n) begin
			if (mem_req && !req_prev) begin
				check_true(!mem_ack, "mem_req rose while mem_ack was still high");
				check_true(acc_q.size() > 0, "memory request with no load or store pending");
				a = acc_q.pop_front();
				check_val("mem_we", 32'(a.we), 32'(mem_we));
				check_val("mem_addr", a.addr, mem_addr);
				if (a.we)
					check_val("mem_wdata", a.wdata, mem_wdata);
			end
			req_prev <= mem_req;
			if (wb_valid) begin
				check_true(exp_q.size() > 0, "writeback record with no instruction pending");
				e = exp_q.pop_front();
				check_val("wb_we", 32'(e.we), 32'(wb_we));
				check_val("wb_rd", 32'(e.rd), 32'(wb_rd));
				if (e.chk_data)
					check_val("wb_data", e.data, wb_data);
				check_val("br_taken", 32'(e.taken), 32'(br_taken));
				if (e.chk_target)
					check_val("br_target", e.target, br_target);
			end
		end
	end

	initial begin
		void'($urandom(77));
		rows[0]  = '{EX_ALU, ALU_ADD, 32'd5, 32'd7, 0, 5'd1, 0, 0, 0, 1'b0};
		rows[1]  = '{EX_ALU, ALU_SUB, 32'd3, 32'd10, 0, 5'd2, 0, 0, 0, 1'b0};
		rows[2]  = '{EX_ALU, ALU_AND, 32'hf0f0, 32'hff00, 0, 5'd3, 0, 0, 0, 1'b0};
		rows[3]  = '{EX_ALU, ALU_OR, 32'h0f00, 32'h00f0, 0, 5'd4, 0, 0, 0, 1'b0};
		rows[4]  = '{EX_ALU, ALU_XOR, 32'haaaa, 32'hffff, 0, 5'd5, 0, 0, 0, 1'b0};
		rows[5]  = '{EX_ALU, ALU_SLL, 32'd1, 32'd35, 0, 5'd6, 0, 0, 0, 1'b0}; // shamt 3
		rows[6]  = '{EX_ALU, ALU_SRL, 32'h8000_0000, 32'd4, 0, 5'd7, 0, 0, 0, 1'b0};
		rows[7]  = '{EX_ALU, ALU_SLT, 32'hffff_ffff, 32'd1, 0, 5'd8, 0, 0, 0, 1'b0};
		rows[8]  = '{EX_BRANCH, ALU_SUB, 32'd5, 32'd5, 0, 5'd0, 32'h100, 32'h20, 0, 1'b0};
		rows[9]  = '{EX_BRANCH, ALU_XOR, 32'd5, 32'd6, 0, 5'd0, 32'h200, 32'h40, 2, 1'b0};
		rows[10] = '{EX_STORE, ALU_SUB, 32'h1000, 32'd8, 32'hdead_beef, 5'd0, 0, 0, 0, 1'b0};
		rows[11] = '{EX_LOAD, ALU_XOR, 32'h1000, 32'd8, 0, 5'd10, 0, 0, 0, 1'b0};
		rows[12] = '{EX_ALU, ALU_ADD, 32'd100, 32'd23, 0, 5'd11, 0, 0, 3, 1'b0};
		rows[13] = '{EX_STORE, ALU_ADD, 32'h2000, 32'd0, 32'h1234_5678, 5'd0, 0, 0, 1, 1'b0};
		rows[14] = '{EX_ALU, ALU_OR, 32'd1, 32'd2, 0, 5'd12, 0, 0, 0, 1'b0};
		rows[15] = '{EX_LOAD, ALU_ADD, 32'h2000, 32'd0, 0, 5'd13, 0, 0, 0, 1'b0};
		rows[16] = '{EX_LOAD, ALU_ADD, 32'h3000, 32'd4, 0, 5'd14, 0, 0, 0, 1'b0};
		rows[17] = '{EX_ALU, ALU_SLT, 32'd3, 32'hffff_fffe, 0, 5'd15, 0, 0, 1, 1'b0};
		rows[18] = '{EX_BRANCH, ALU_SLT, 32'd1, 32'd2, 0, 5'd0, 32'h300, 32'hfffffff0, 0, 1'b0};
		rows[19] = '{EX_LOAD, ALU_ADD, 32'h4000, 32'd0, 0, 5'd9, 0, 0, 0, 1'b1}; // no ack

		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_val("id_ready", 32'd1, 32'(id_ready));
		check_val("ex_valid", 32'd0, 32'(dut.ex_valid));
		check_val("mem_req", 32'd0, 32'(mem_req));
		check_val("wb_valid", 32'd0, 32'(wb_valid));
		check_val("mem_err", 32'd0, 32'(mem_err));

		for (int i = 0; i < ROWS; i++) begin
			@(posedge clk);
			id_valid  <= 1'b1;
			id_kind   <= rows[i].kind;
			id_alu_op <= rows[i].op;
			id_op1    <= rows[i].op1;
			id_op2    <= rows[i].op2;
			id_rs2o   <= rows[i].rs2o;
			id_rd     <= rows[i].rd;
			id_pc     <= rows[i].pc;
			id_imm    <= rows[i].imm;
			stall     <= (rows[i].stall_n > 0); // bundle parks in the hold slot
			mute      <= rows[i].mute;
			do @(negedge clk); while (!id_ready);
			@(posedge clk); // accepted on this edge
			id_valid <= 1'b0;
			exp_q.push_back(expect_rec(rows[i]));
			if (rows[i].stall_n > 0) begin
				repeat (rows[i].stall_n - 1) @(posedge clk);
				stall <= 1'b0;
			end
		end

		while (exp_q.size() > 0)
			@(negedge clk);
		repeat (5) @(negedge clk); // any extra record shows up here
		check_val("mem_err", 32'd1, 32'(mem_err));
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

//--- sim/tb_mem_model.sv
`timescale 1ns/1ps
`include "ex_consts.svh"

module tb_mem_model (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                mute,
	input  logic                req,
	input  logic                we,
	input  logic [`EX_XLEN-1:0] addr,
	input  logic [`EX_XLEN-1:0] wdata,
	output logic                ack,
	output logic [`EX_XLEN-1:0] rdata
);

	logic [`EX_XLEN-1:0] store [logic [`EX_XLEN-1:0]]; // written words only
	logic [1:0]          dly;

	// unwritten words read back as a function of the full address
	function automatic logic [`EX_XLEN-1:0] read_word(input logic [`EX_XLEN-1:0] a);
		if (store.exists(a))
			return store[a];
		return a ^ 32'h5a5a_c3c3;
	endfunction

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack   <= 1'b0;
			rdata <= '0;
			dly   <= '0;
		end else if (req && !ack && !mute) begin
			if (dly == 0) begin
				ack <= 1'b1;
				if (we)
					store[addr] = wdata;
				else
					rdata <= read_word(addr);
				dly <= 2'($urandom % 4); // delay for the next access
			end else begin
				dly <= dly - 1'b1;
			end
		end else if (!req && ack) begin
			ack <= 1'b0; // release phase
		end
	end

endmodule

//--- hw/ex_stage_top.sv
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_stage_top import ex_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   stall,
	input  logic                   id_valid,
	input  ex_kind_e               id_kind,
	input  alu_op_e                id_alu_op,
	input  logic [`EX_XLEN-1:0]    id_op1,
	input  logic [`EX_XLEN-1:0]    id_op2,
	input  logic [`EX_XLEN-1:0]    id_rs2o,
	input  logic [`EX_RADDR_W-1:0] id_rd,
	input  logic [`EX_XLEN-1:0]    id_pc,
	input  logic [`EX_XLEN-1:0]    id_imm,
	output logic                   id_ready,
	output logic                   mem_req,
	output logic                   mem_we,
	output logic [`EX_XLEN-1:0]    mem_addr,
	output logic [`EX_XLEN-1:0]    mem_wdata,
	input  logic                   mem_ack,
	input  logic [`EX_XLEN-1:0]    mem_rdata,
	output logic                   wb_valid,
	output logic                   wb_we,
	output logic [`EX_RADDR_W-1:0] wb_rd,
	output logic [`EX_XLEN-1:0]    wb_data,
	output logic                   br_taken,
	output logic [`EX_XLEN-1:0]    br_target,
	output logic                   mem_err
);

	logic                   ex_valid;
	ex_kind_e               ex_kind;
	alu_op_e                ex_alu_op;
	logic [`EX_XLEN-1:0]    ex_op1, ex_op2, ex_rs2o, ex_pc, ex_imm;
	logic [`EX_RADDR_W-1:0] ex_rd;
	logic [`EX_XLEN-1:0]    alu_result, br_target_c, load_data;
	logic                   br_taken_c;
	logic                   mem_busy, mem_done;
	logic                   wait_run, wait_expired;

	id_ex_reg u_id_ex (.*);

	ex_alu u_alu (.*);

	mem_access_fsm u_mem (.*);

	ack_wait_timer u_timer (
		.clk          (clk),
		.rst_n        (rst_n),
		.wait_run     (wait_run),
		.wait_expired (wait_expired)
	);

	ex_wb_reg u_wb (.*);

endmodule

//--- hw/ex_wb_reg.sv
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_wb_reg import ex_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   ex_valid,
	input  ex_kind_e               ex_kind,
	input  logic [`EX_RADDR_W-1:0] ex_rd,
	input  logic [`EX_XLEN-1:0]    alu_result,
	input  logic [`EX_XLEN-1:0]    load_data,
	input  logic                   br_taken_c,
	input  logic [`EX_XLEN-1:0]    br_target_c,
	input  logic                   mem_busy,
	input  logic                   mem_done,
	input  logic                   mem_err,
	output logic                   wb_valid,
	output logic                   wb_we,
	output logic [`EX_RADDR_W-1:0] wb_rd,
	output logic [`EX_XLEN-1:0]    wb_data,
	output logic                   br_taken,
	output logic [`EX_XLEN-1:0]    br_target
);

	logic is_mem;
	logic capture;
	logic writes_rd;

	assign is_mem  = (ex_kind == EX_LOAD) || (ex_kind == EX_STORE);
	assign capture = (ex_valid && !is_mem && !mem_busy) || mem_done;

	// a failed load must not update the register file
	assign writes_rd = (ex_kind == EX_ALU) || (ex_kind == EX_LOAD && !mem_err);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
			wb_we    <= 1'b0;
		end else begin
			wb_valid <= capture; // one-cycle record
			wb_we    <= capture && writes_rd;
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			wb_rd     <= ex_rd;
			wb_data   <= (ex_kind == EX_LOAD) ? load_data : alu_result;
			br_taken  <= br_taken_c;
			br_target <= br_target_c;
		end
	end

endmodule

//--- hw/ack_wait_timer.sv
`timescale 1ns/1ps
`include "ex_consts.svh"

module ack_wait_timer (
	input  logic clk,
	input  logic rst_n,
	input  logic wait_run,
	output logic wait_expired
);

	localparam int CNT_W = $clog2(`EX_ACK_TIMEOUT + 1);

	logic [CNT_W-1:0] wait_cnt;

	// counts across both waiting phases of one access
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wait_cnt <= '0;
		else if (!wait_run)
			wait_cnt <= '0;
		else if (!wait_expired)
			wait_cnt <= wait_cnt + 1'b1; // saturates at the limit
	end

	assign wait_expired = (wait_cnt == CNT_W'(`EX_ACK_TIMEOUT));

endmodule

//--- hw/mem_access_fsm.sv
`timescale 1ns/1ps
`include "ex_consts.svh"

module mem_access_fsm import ex_pkg::*; (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                ex_valid,
	input  ex_kind_e            ex_kind,
	input  logic [`EX_XLEN-1:0] alu_result,
	input  logic [`EX_XLEN-1:0] ex_rs2o,
	input  logic                mem_ack,
	input  logic [`EX_XLEN-1:0] mem_rdata,
	input  logic                wait_expired,
	output logic                mem_req,
	output logic                mem_we,
	output logic [`EX_XLEN-1:0] mem_addr,
	output logic [`EX_XLEN-1:0] mem_wdata,
	output logic                mem_busy,
	output logic                mem_done,
	output logic [`EX_XLEN-1:0] load_data,
	output logic                wait_run,
	output logic                mem_err
);

	mem_state_e state;
	mem_state_e state_nx;
	logic       is_mem;

	assign is_mem = ex_valid && (ex_kind == EX_LOAD || ex_kind == EX_STORE);

	always_comb begin
		state_nx = state;
		case (state)
			MS_IDLE:
				if (is_mem)
					state_nx = MS_REQ;
			MS_REQ:
				if (wait_expired)
					state_nx = MS_DONE;
				else if (mem_ack)
					state_nx = MS_RELEASE;
			MS_RELEASE:
				if (wait_expired || !mem_ack)
					state_nx = MS_DONE;
			default:
				state_nx = MS_IDLE; // done lasts one cycle
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= MS_IDLE;
			mem_err <= 1'b0;
		end else begin
			state <= state_nx;
			if (wait_run && wait_expired)
				mem_err <= 1'b1; // held until reset
		end
	end

	always_ff @(posedge clk) begin
		if (state == MS_REQ && mem_ack)
			load_data <= mem_rdata;
	end

	// EX is frozen during the access, so address and data stay put
	assign mem_req   = (state == MS_REQ);
	assign mem_we    = is_mem && (ex_kind == EX_STORE);
	assign mem_addr  = alu_result;
	assign mem_wdata = ex_rs2o;

	assign mem_busy = is_mem && (state != MS_DONE);
	assign mem_done = (state == MS_DONE);
	assign wait_run = (state == MS_REQ) || (state == MS_RELEASE);

endmodule

//--- hw/ex_alu.sv
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_alu import ex_pkg::*; (
	input  alu_op_e                ex_alu_op,
	input  ex_kind_e               ex_kind,
	input  logic [`EX_XLEN-1:0]    ex_op1,
	input  logic [`EX_XLEN-1:0]    ex_op2,
	input  logic [`EX_XLEN-1:0]    ex_pc,
	input  logic [`EX_XLEN-1:0]    ex_imm,
	output logic [`EX_XLEN-1:0]    alu_result,
	output logic                   br_taken_c,
	output logic [`EX_XLEN-1:0]    br_target_c
);

	localparam int SHAMT_W = $clog2(`EX_XLEN);

	alu_op_e                op;
	logic [SHAMT_W-1:0]     shamt;
	logic                   lt;

	// loads and stores compute base plus offset
	assign op    = (ex_kind == EX_LOAD || ex_kind == EX_STORE) ? ALU_ADD : ex_alu_op;
	assign shamt = ex_op2[SHAMT_W-1:0];
	assign lt    = $signed(ex_op1) < $signed(ex_op2);

	always_comb begin
		case (op)
			ALU_ADD: alu_result = ex_op1 + ex_op2;
			ALU_SUB: alu_result = ex_op1 - ex_op2;
			ALU_AND: alu_result = ex_op1 & ex_op2;
			ALU_OR:  alu_result = ex_op1 | ex_op2;
			ALU_XOR: alu_result = ex_op1 ^ ex_op2;
			ALU_SLL: alu_result = ex_op1 << shamt;
			ALU_SRL: alu_result = ex_op1 >> shamt; // logical
			ALU_SLT: alu_result = {{(`EX_XLEN-1){1'b0}}, lt};
			default: alu_result = '0;
		endcase
	end

	// branch condition is any non-zero compare result
	assign br_taken_c  = (ex_kind == EX_BRANCH) && (|alu_result);
	assign br_target_c = ex_pc + ex_imm;

endmodule

//--- hw/id_ex_reg.sv
`timescale 1ns/1ps
`include "ex_consts.svh"

module id_ex_reg import ex_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   stall,
	input  logic                   mem_busy,
	input  logic                   mem_done,
	input  logic                   id_valid,
	input  ex_kind_e               id_kind,
	input  alu_op_e                id_alu_op,
	input  logic [`EX_XLEN-1:0]    id_op1,
	input  logic [`EX_XLEN-1:0]    id_op2,
	input  logic [`EX_XLEN-1:0]    id_rs2o,
	input  logic [`EX_RADDR_W-1:0] id_rd,
	input  logic [`EX_XLEN-1:0]    id_pc,
	input  logic [`EX_XLEN-1:0]    id_imm,
	output logic                   id_ready,
	output logic                   ex_valid,
	output ex_kind_e               ex_kind,
	output alu_op_e                ex_alu_op,
	output logic [`EX_XLEN-1:0]    ex_op1,
	output logic [`EX_XLEN-1:0]    ex_op2,
	output logic [`EX_XLEN-1:0]    ex_rs2o,
	output logic [`EX_RADDR_W-1:0] ex_rd,
	output logic [`EX_XLEN-1:0]    ex_pc,
	output logic [`EX_XLEN-1:0]    ex_imm
);

	// one-entry hold slot for a bundle that arrives under stall
	logic                   hold_full;
	ex_kind_e               hold_kind;
	alu_op_e                hold_alu_op;
	logic [`EX_XLEN-1:0]    hold_op1;
	logic [`EX_XLEN-1:0]    hold_op2;
	logic [`EX_XLEN-1:0]    hold_rs2o;
	logic [`EX_RADDR_W-1:0] hold_rd;
	logic [`EX_XLEN-1:0]    hold_pc;
	logic [`EX_XLEN-1:0]    hold_imm;

	logic accept;
	logic advance;
	logic take_hold;
	logic take_new;
	logic park;

	assign id_ready = !hold_full && !mem_busy;
	assign accept   = id_valid && id_ready;
	assign advance  = !mem_busy || mem_done; // memory op retires on done

	assign take_hold = advance && !stall && hold_full;
	assign take_new  = advance && !stall && !hold_full && accept;
	assign park      = advance && stall && accept;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_valid  <= 1'b0;
			hold_full <= 1'b0;
		end else if (advance) begin
			ex_valid <= take_hold || take_new; // bubble otherwise
			if (park)
				hold_full <= 1'b1;
			else if (take_hold)
				hold_full <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (park) begin
			hold_kind   <= id_kind;
			hold_alu_op <= id_alu_op;
			hold_op1    <= id_op1;
			hold_op2    <= id_op2;
			hold_rs2o   <= id_rs2o;
			hold_rd     <= id_rd;
			hold_pc     <= id_pc;
			hold_imm    <= id_imm;
		end
		if (take_hold) begin // replay the parked bundle first
			ex_kind   <= hold_kind;
			ex_alu_op <= hold_alu_op;
			ex_op1    <= hold_op1;
			ex_op2    <= hold_op2;
			ex_rs2o   <= hold_rs2o;
			ex_rd     <= hold_rd;
			ex_pc     <= hold_pc;
			ex_imm    <= hold_imm;
		end else if (take_new) begin
			ex_kind   <= id_kind;
			ex_alu_op <= id_alu_op;
			ex_op1    <= id_op1;
			ex_op2    <= id_op2;
			ex_rs2o   <= id_rs2o;
			ex_rd     <= id_rd;
			ex_pc     <= id_pc;
			ex_imm    <= id_imm;
		end
	end

endmodule

//--- hw/ex_pkg.sv
package ex_pkg;

	// instruction class seen by the execute slice
	typedef enum logic [1:0] {
		EX_ALU,
		EX_LOAD,
		EX_STORE,
		EX_BRANCH
	} ex_kind_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SLT // signed compare
	} alu_op_e;

	// data memory handshake controller
	typedef enum logic [1:0] {
		MS_IDLE,
		MS_REQ,     // req high, waiting for ack
		MS_RELEASE, // req low, waiting for ack to drop
		MS_DONE
	} mem_state_e;

endpackage

//--- hw/ex_consts.svh
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// datapath and memory address width
`define EX_XLEN 32

// destination register index width
`define EX_RADDR_W 5

// cycles spent waiting on mem_ack before an access is abandoned
// covers both the ack-high and the ack-low phase
`define EX_ACK_TIMEOUT 64

`endif
